// ==== lc4_pkg.sv ====
package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int NUM_REGS  = 8;
    // pairing logic assumes exactly two lanes
    localparam int NUM_LANES = 2;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0]                  nzp_t;

    typedef enum logic [3:0] {
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_CONST = 4'b1001
    } opcode_e;

    // sub-op field, insn[4:3]
    localparam logic [1:0] ARITH_ADD = 2'b00;
    localparam logic [1:0] ARITH_SUB = 2'b10;
    localparam logic [1:0] LOGIC_AND = 2'b00;
    localparam logic [1:0] LOGIC_NOT = 2'b01;
    localparam logic [1:0] LOGIC_OR  = 2'b10;
    localparam logic [1:0] LOGIC_XOR = 2'b11;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic       imm;
        logic [1:0] sub_op;
        reg_idx_t   rt;
    } insn_reg_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic       imm;
        logic [4:0] imm5;
    } insn_imm_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        logic [8:0] imm9;
    } insn_const_t;

    // bit 5 picks between the register and immediate view
    typedef union packed {
        insn_reg_t   r;
        insn_imm_t   i;
        insn_const_t c;
    } insn_u;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
    } dec_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_u insn;
        dec_t  dec;
    } slot_t;

    typedef struct packed {
        slot_t slot;
        word_t result;
        nzp_t  nzp;
    } stage_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rd_we;
        reg_idx_t rd;
        word_t    data;
        logic     nzp_we;
        nzp_t     nzp;
    } retire_t;

    function automatic dec_t lc4_decode(input insn_u insn);
        dec_t d;
        d       = '0;
        d.rs    = insn.r.rs;
        d.rt    = insn.r.rt;
        d.rd    = insn.r.rd;
        case (insn.r.opcode)
            OP_ARITH: begin
                // MUL and DIV are not supported and fall through as no-ops
                if (insn.r.imm || insn.r.sub_op == ARITH_ADD || insn.r.sub_op == ARITH_SUB) begin
                    d.rs_re  = 1'b1;
                    d.rt_re  = !insn.r.imm;
                    d.rd_we  = 1'b1;
                    d.nzp_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                d.rs_re  = 1'b1;
                d.rt_re  = !insn.r.imm && (insn.r.sub_op != LOGIC_NOT);
                d.rd_we  = 1'b1;
                d.nzp_we = 1'b1;
            end
            OP_CONST: begin
                d.rd_we  = 1'b1;
                d.nzp_we = 1'b1;
            end
            default: begin
                d.rd_we  = 1'b0;
            end
        endcase
        return d;
    endfunction

endpackage

// ==== lc4_alu.sv ====
`timescale 1ns/1ns

module lc4_alu import lc4_pkg::*; (
    input  insn_u i_insn,
    input  word_t i_rs,
    input  word_t i_rt,
    output word_t o_result,
    output nzp_t  o_nzp
);

    word_t imm5_sx;
    word_t imm9_sx;

    assign imm5_sx = {{(WORD_W-5){i_insn.i.imm5[4]}}, i_insn.i.imm5};
    assign imm9_sx = {{(WORD_W-9){i_insn.c.imm9[8]}}, i_insn.c.imm9};

    always_comb begin
        o_result = '0;
        case (i_insn.r.opcode)
            OP_ARITH: begin
                if (i_insn.i.imm) begin
                    o_result = i_rs + imm5_sx;
                end else if (i_insn.r.sub_op == ARITH_SUB) begin
                    o_result = i_rs - i_rt;
                end else begin
                    o_result = i_rs + i_rt;
                end
            end
            OP_LOGIC: begin
                if (i_insn.i.imm) begin
                    o_result = i_rs & imm5_sx;
                end else begin
                    case (i_insn.r.sub_op)
                        LOGIC_AND: o_result = i_rs & i_rt;
                        LOGIC_NOT: o_result = ~i_rs;
                        LOGIC_OR:  o_result = i_rs | i_rt;
                        LOGIC_XOR: o_result = i_rs ^ i_rt;
                        default:   o_result = '0;
                    endcase
                end
            end
            OP_CONST: begin
                o_result = imm9_sx;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // exactly one flag, taken from the signed result
    always_comb begin
        if (o_result[WORD_W-1]) begin
            o_nzp = 3'b100;
        end else if (o_result == '0) begin
            o_nzp = 3'b010;
        end else begin
            o_nzp = 3'b001;
        end
    end

endmodule

// ==== lc4_regfile.sv ====
`timescale 1ns/1ns

module lc4_regfile import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_arst_n,
    input  reg_idx_t i_rd_idx [2*NUM_LANES],
    output word_t    o_rd_data [2*NUM_LANES],
    input  retire_t  i_wr [NUM_LANES]
);

    word_t regs_q [NUM_REGS];

    // later lane is written last, so lane B wins a same-register conflict
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (i_wr[l].valid && i_wr[l].rd_we) begin
                    regs_q[i_wr[l].rd] <= i_wr[l].data;
                end
            end
        end
    end

    // write-through so a read in the same cycle as the write sees the new value
    always_comb begin
        for (int p = 0; p < 2*NUM_LANES; p++) begin
            o_rd_data[p] = regs_q[i_rd_idx[p]];
            for (int l = 0; l < NUM_LANES; l++) begin
                if (i_wr[l].valid && i_wr[l].rd_we && (i_wr[l].rd == i_rd_idx[p])) begin
                    o_rd_data[p] = i_wr[l].data;
                end
            end
        end
    end

endmodule

// ==== lc4_issue.sv ====
`timescale 1ns/1ns

module lc4_issue import lc4_pkg::*; #(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic  gwe,
    input  logic  i_arst_n,
    input  word_t i_insn_a,
    input  word_t i_insn_b,
    output word_t o_cur_pc,
    output slot_t o_slot [NUM_LANES]
);

    word_t pc_q;
    word_t pc_next;
    slot_t slot_q [NUM_LANES];
    slot_t slot_next [NUM_LANES];
    slot_t fetch_a;
    slot_t fetch_b;
    logic  b_needs_a;

    // words from memory, at pc and pc+1
    always_comb begin
        fetch_a.valid = 1'b1;
        fetch_a.pc    = pc_q;
        fetch_a.insn  = i_insn_a;
        fetch_a.dec   = lc4_decode(i_insn_a);

        fetch_b.valid = 1'b1;
        fetch_b.pc    = pc_q + WORD_W'(1);
        fetch_b.insn  = i_insn_b;
        fetch_b.dec   = lc4_decode(i_insn_b);
    end

    // B reads something A writes in the same pair
    assign b_needs_a = slot_q[0].valid && slot_q[1].valid && slot_q[0].dec.rd_we &&
                       ((slot_q[1].dec.rs_re && (slot_q[1].dec.rs == slot_q[0].dec.rd)) ||
                        (slot_q[1].dec.rt_re && (slot_q[1].dec.rt == slot_q[0].dec.rd)));

    always_comb begin
        if (b_needs_a) begin
            // old B moves up to A, only one new word is taken
            slot_next[0] = slot_q[1];
            slot_next[1] = fetch_a;
            pc_next      = pc_q + WORD_W'(1);
        end else begin
            slot_next[0] = fetch_a;
            slot_next[1] = fetch_b;
            pc_next      = pc_q + WORD_W'(2);
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= RESET_PC;
            for (int l = 0; l < NUM_LANES; l++) begin
                slot_q[l].valid <= 1'b0;
            end
        end else begin
            pc_q   <= pc_next;
            slot_q <= slot_next;
        end
    end

    assign o_cur_pc = pc_q;

    always_comb begin
        o_slot[0] = slot_q[0];
        o_slot[1] = slot_q[1];
        // held-back B enters its X stage as a bubble
        o_slot[1].valid = slot_q[1].valid && !b_needs_a;
    end

endmodule

// ==== lc4_lane.sv ====
`timescale 1ns/1ns

module lc4_lane import lc4_pkg::*; (
    input  logic    gwe,
    input  logic    i_arst_n,
    input  slot_t   i_slot,
    input  word_t   i_rs_data,
    input  word_t   i_rt_data,
    input  stage_t  i_m_stages [NUM_LANES],
    input  stage_t  i_w_stages [NUM_LANES],
    output stage_t  o_m_stage,
    output stage_t  o_w_stage,
    output retire_t o_retire
);

    slot_t  x_q;
    word_t  x_rs_q;
    word_t  x_rt_q;
    stage_t m_q;
    stage_t w_q;
    word_t  rs_val;
    word_t  rt_val;
    word_t  alu_result;
    nzp_t   alu_nzp;

    function automatic logic stage_hit(input stage_t s, input reg_idx_t idx);
        return s.slot.valid && s.slot.dec.rd_we && (s.slot.dec.rd == idx);
    endfunction

    // checked from lowest to highest priority, the last hit wins
    // so M beats W and lane B beats lane A
    function automatic word_t forward(
        input reg_idx_t idx,
        input word_t    rf_val,
        input stage_t   m_s [NUM_LANES],
        input stage_t   w_s [NUM_LANES]
    );
        word_t val;
        val = rf_val;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (stage_hit(w_s[l], idx)) begin
                val = w_s[l].result;
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (stage_hit(m_s[l], idx)) begin
                val = m_s[l].result;
            end
        end
        return val;
    endfunction

    always_comb begin
        rs_val = forward(x_q.dec.rs, x_rs_q, i_m_stages, i_w_stages);
        rt_val = forward(x_q.dec.rt, x_rt_q, i_m_stages, i_w_stages);
    end

    lc4_alu u_alu (
        .i_insn   (x_q.insn),
        .i_rs     (rs_val),
        .i_rt     (rt_val),
        .o_result (alu_result),
        .o_nzp    (alu_nzp)
    );

    // X, M and W advance every cycle, reset only drops the valid bits
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_q.valid      <= 1'b0;
            m_q.slot.valid <= 1'b0;
            w_q.slot.valid <= 1'b0;
        end else begin
            x_q        <= i_slot;
            x_rs_q     <= i_rs_data;
            x_rt_q     <= i_rt_data;
            m_q.slot   <= x_q;
            m_q.result <= alu_result;
            m_q.nzp    <= alu_nzp;
            w_q        <= m_q;
        end
    end

    assign o_m_stage = m_q;
    assign o_w_stage = w_q;

    // W entry doubles as the register file write
    always_comb begin
        o_retire.valid  = w_q.slot.valid;
        o_retire.pc     = w_q.slot.pc;
        o_retire.insn   = w_q.slot.insn;
        o_retire.rd_we  = w_q.slot.valid && w_q.slot.dec.rd_we;
        o_retire.rd     = w_q.slot.dec.rd;
        o_retire.data   = w_q.result;
        o_retire.nzp_we = w_q.slot.valid && w_q.slot.dec.nzp_we;
        o_retire.nzp    = w_q.nzp;
    end

endmodule

// ==== lc4_superscalar.sv ====
`timescale 1ns/1ns

module lc4_superscalar import lc4_pkg::*; #(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic    gwe,
    input  logic    i_arst_n,
    output word_t   o_cur_pc,
    input  word_t   i_insn_a,
    input  word_t   i_insn_b,
    output retire_t o_retire [NUM_LANES]
);

    slot_t    slot [NUM_LANES];
    reg_idx_t rd_idx [2*NUM_LANES];
    word_t    rd_data [2*NUM_LANES];
    stage_t   m_stages [NUM_LANES];
    stage_t   w_stages [NUM_LANES];

    lc4_issue #(
        .RESET_PC (RESET_PC)
    ) u_issue (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_cur_pc (o_cur_pc),
        .o_slot   (slot)
    );

    // lane l reads through ports 2l (rs) and 2l+1 (rt)
    generate
        for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
            assign rd_idx[2*g]   = slot[g].dec.rs;
            assign rd_idx[2*g+1] = slot[g].dec.rt;

            lc4_lane u_lane (
                .gwe        (gwe),
                .i_arst_n   (i_arst_n),
                .i_slot     (slot[g]),
                .i_rs_data  (rd_data[2*g]),
                .i_rt_data  (rd_data[2*g+1]),
                .i_m_stages (m_stages),
                .i_w_stages (w_stages),
                .o_m_stage  (m_stages[g]),
                .o_w_stage  (w_stages[g]),
                .o_retire   (o_retire[g])
            );
        end
    endgenerate

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rd_idx  (rd_idx),
        .o_rd_data (rd_data),
        .i_wr      (o_retire)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

    // released on a falling edge, away from the rising edge that samples it
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

// ==== tb_lc4_superscalar.sv ====
`timescale 1ns/1ns

module tb_lc4_superscalar import lc4_pkg::*; ();

    localparam word_t RESET_PC       = 16'h8200;
    localparam int    NUM_CHECKS     = 600;
    localparam int    RESET_TIMEOUT  = 40;
    localparam int    RETIRE_TIMEOUT = 50;

    logic    gwe;
    logic    arst_n;
    word_t   cur_pc;
    word_t   insn_a;
    word_t   insn_b;
    retire_t retire [NUM_LANES];

    word_t   imem [2**WORD_W];
    word_t   model_regs [NUM_REGS];
    word_t   exp_pc     = RESET_PC;
    int      seed       = 16;
    int      value_errs = 0;
    int      other_errs = 0;
    int      checked    = 0;
    int      idle       = 0;
    int      waited     = 0;
    int      splits     = 0;

    tb_clkgen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (16)
    ) u_clkgen (
        .o_clk    (gwe),
        .o_arst_n (arst_n)
    );

    lc4_superscalar #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .gwe      (gwe),
        .i_arst_n (arst_n),
        .o_cur_pc (cur_pc),
        .i_insn_a (insn_a),
        .i_insn_b (insn_b),
        .o_retire (retire)
    );

    // instruction memory, words at pc and pc+1
    always @(negedge gwe) begin
        insn_a <= imem[cur_pc];
        insn_b <= imem[cur_pc + 16'd1];
    end

    // mostly supported forms, MUL/DIV and foreign opcodes now and then
    function automatic word_t random_insn();
        word_t w;
        int    pick;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 8;
        case (pick)
            0, 1, 7: w[15:12] = 4'b0001;
            2, 3, 4: w[15:12] = 4'b0101;
            5:       w[15:12] = 4'b1001;
            default: w[15:12] = {w[15:14], 2'b11};
        endcase
        // register ARITH keeps to ADD and SUB unless pick is 7
        if (pick < 2 && !w[5]) begin
            w[3] = 1'b0;
        end
        return w;
    endfunction

    // one instruction on the model registers, straight from the LC4 encoding
    function automatic retire_t ref_exec(input word_t pc, input word_t insn);
        retire_t r;
        word_t   vs;
        word_t   vt;
        word_t   sx5;
        logic    ok;
        vs      = model_regs[insn[8:6]];
        vt      = model_regs[insn[2:0]];
        sx5     = {{11{insn[4]}}, insn[4:0]};
        ok      = 1'b1;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.insn  = insn;
        r.rd    = insn[11:9];
        casez ({insn[15:12], insn[5], insn[4:3]})
            7'b0001_1_??: r.data = vs + sx5;
            7'b0001_0_00: r.data = vs + vt;
            7'b0001_0_10: r.data = vs - vt;
            7'b0101_1_??: r.data = vs & sx5;
            7'b0101_0_00: r.data = vs & vt;
            7'b0101_0_01: r.data = ~vs;
            7'b0101_0_10: r.data = vs | vt;
            7'b0101_0_11: r.data = vs ^ vt;
            7'b1001_?_??: r.data = {{7{insn[8]}}, insn[8:0]};
            default:      ok = 1'b0;
        endcase
        r.rd_we  = ok;
        r.nzp_we = ok;
        r.nzp    = r.data[15] ? 3'b100 : ((r.data == '0) ? 3'b010 : 3'b001);
        return r;
    endfunction

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        retire_t a;
        a = act;
        // rd, data and nzp mean nothing while their write enable is clear
        if (!exp.valid) begin
            a       = exp;
            a.valid = act.valid;
        end
        if (!exp.rd_we) begin
            a.rd   = exp.rd;
            a.data = exp.data;
        end
        if (!exp.nzp_we) begin
            a.nzp = exp.nzp;
        end
        if (a !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    initial begin
        retire_t expected;
        insn_a = '0;
        insn_b = '0;
        for (int a = 0; a < 2**WORD_W; a++) begin
            imem[a] = random_insn();
        end
        // register file clears on reset
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        // reset state, sampled at a falling edge while reset is held
        @(negedge gwe);
        check_word("reset_pc", RESET_PC, cur_pc);
        check_retire("reset_retire_a", '0, retire[0]);
        check_retire("reset_retire_b", '0, retire[1]);
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge gwe);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            other_errs++;
        end else begin
            while (checked < NUM_CHECKS && idle < RETIRE_TIMEOUT) begin
                // retire outputs are stable between rising edges
                @(negedge gwe);
                idle++;
                // lane A is older than lane B in the same cycle
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (retire[l].valid) begin
                        expected = ref_exec(exp_pc, imem[exp_pc]);
                        check_retire($sformatf("retire_%0d_pc_%h", checked, exp_pc),
                                     expected, retire[l]);
                        if (expected.rd_we) begin
                            model_regs[expected.rd] = expected.data;
                        end
                        exp_pc = exp_pc + 16'd1;
                        checked++;
                        idle = 0;
                    end
                end
                // a split pair retires alone in lane A
                if (retire[0].valid && !retire[1].valid) begin
                    splits++;
                end
            end
            if (idle >= RETIRE_TIMEOUT) begin
                $display("no retire within %0d cycles", RETIRE_TIMEOUT);
                other_errs++;
            end else if (splits == 0) begin
                $display("no pair was split during the run");
                other_errs++;
            end
        end
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
lc4_pkg.sv
lc4_alu.sv
lc4_regfile.sv
lc4_issue.sv
lc4_lane.sv
lc4_superscalar.sv
tb_clkgen.sv
tb_lc4_superscalar.sv
